/* Makefile */
# Verilator build and run for the control unit testbench.

VERILATOR ?= verilator
TOP       ?= controlUnitTb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "failure found in $(LOG)"; exit 1; fi
	@if ! grep -q "sim passed" $(LOG); then echo "no result line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hdl/busWatchdog.sv */
`timescale 1ns/1ps

module busWatchdog (
    input  logic clk,
    input  logic rst,
    input  logic busStalled,
    output logic timeout
);
    import ctrlPkg::*;

    stallCountT stallCount;
    logic       atLimit;

    assign atLimit = (stallCount == stallCountT'(busTimeoutCycles));
    assign timeout = atLimit;

    // counts consecutive stalled cycles only.
    always_ff @(posedge clk) begin
        if (rst) begin
            stallCount <= '0;
        end else if (!busStalled) begin
            stallCount <= '0;
        end else if (!atLimit) begin
            stallCount <= stallCount + 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        stallCount <= stallCountT'(busTimeoutCycles));

endmodule

/* hdl/controlEncoder.sv */
`timescale 1ns/1ps

module controlEncoder (
    input  ctrlPkg::phaseT      phase,
    input  ctrlPkg::instrClassT instrClass,
    input  logic                waitRequest,
    input  logic                branchTaken,
    output ctrlPkg::memToRegT   memToReg,
    output ctrlPkg::regDstT     regDst,
    output ctrlPkg::pcSrcT      pcSrc,
    output ctrlPkg::iorDT       iorD,
    output ctrlPkg::aluSrcAT    aluSrcA,
    output ctrlPkg::aluSrcBT    aluSrcB,
    output ctrlPkg::extendT     extendMode,
    output ctrlPkg::aluOpT      aluOp,
    output logic                irWrite,
    output logic                memRead,
    output logic                memWrite,
    output logic                pcWrite,
    output logic                regWrite,
    output logic                busFault
);
    import ctrlPkg::*;

    assign busFault = (phase == phaseFault);

    always_comb begin
        // defaults drive pc + 4 through the ALU.
        memToReg   = wbAlu;
        regDst     = dstRt;
        pcSrc      = pcSeq;
        iorD       = addrPc;
        aluSrcA    = srcAPc;
        aluSrcB    = srcBFour;
        extendMode = extSign;
        aluOp      = aluAdd;
        irWrite    = 1'b0;
        memRead    = 1'b0;
        memWrite   = 1'b0;
        pcWrite    = 1'b0;
        regWrite   = 1'b0;

        case (phase)
            phaseFetch: begin
                memRead = 1'b1;
                irWrite = !waitRequest; // word and pc update land together.
                pcWrite = !waitRequest;
            end
            phaseExecute: begin
                aluSrcA = (instrClass == classLui) ? srcAZero : srcARegA;
                if (isRTypeAlu(instrClass) || isBranch(instrClass)) begin
                    aluSrcB = srcBRegB;
                end else if (instrClass inside {classAndi, classOri, classXori}) begin
                    aluSrcB    = srcBSignImm;
                    extendMode = extZero; // logical immediates are zero extended.
                end else if (instrClass == classLui) begin
                    aluSrcB = srcBUpperImm;
                end else if (instrClass inside {classAddiu, classSlti, classSltiu,
                                                classLw, classSw}) begin
                    aluSrcB = srcBSignImm;
                end

                case (instrClass)
                    classSubu, classBeq, classBne, classBgez, classBltz: aluOp = aluSub;
                    classAnd, classAndi:   aluOp = aluAnd;
                    classOr, classOri:     aluOp = aluOr;
                    classXor, classXori:   aluOp = aluXor;
                    classSlt, classSlti:   aluOp = aluSlt;
                    classSltu, classSltiu: aluOp = aluSltu;
                    default:               aluOp = aluAdd;
                endcase

                if (isBranch(instrClass)) begin
                    pcSrc   = pcBranchTarget;
                    pcWrite = branchTaken;
                end else if (instrClass == classJ || instrClass == classJal) begin
                    pcSrc   = pcJumpTarget;
                    pcWrite = 1'b1;
                end else if (instrClass == classJr) begin
                    pcSrc   = pcRegA;
                    pcWrite = 1'b1;
                end

                // jal saves the return address in ra alongside the jump.
                if (instrClass == classJal) begin
                    regWrite = 1'b1;
                    regDst   = dstRa;
                    memToReg = wbLinkPc;
                end
            end
            phaseAluWb: begin
                regWrite = 1'b1;
                regDst   = isRTypeAlu(instrClass) ? dstRd : dstRt;
                memToReg = isSltFamily(instrClass) ? wbSltFlag : wbAlu;
            end
            phaseMem: begin
                iorD     = addrAluOut;
                memRead  = (instrClass == classLw);
                memWrite = (instrClass == classSw);
            end
            phaseLoadWb: begin
                regWrite = 1'b1;
                memToReg = wbMem;
                regDst   = dstRt;
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        assert final (!(memRead && memWrite));
        assert final (!irWrite || memRead);
    end

endmodule

/* hdl/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit (
    input  logic              clk,
    input  logic              rst,
    input  ctrlPkg::opcodeT   opcode,
    input  ctrlPkg::functT    funct,
    input  ctrlPkg::rtFieldT  rtField,
    input  logic              waitRequest,
    input  logic              branchTaken,
    output ctrlPkg::memToRegT memToReg,
    output ctrlPkg::regDstT   regDst,
    output ctrlPkg::pcSrcT    pcSrc,
    output ctrlPkg::iorDT     iorD,
    output ctrlPkg::aluSrcAT  aluSrcA,
    output ctrlPkg::aluSrcBT  aluSrcB,
    output ctrlPkg::extendT   extendMode,
    output ctrlPkg::aluOpT    aluOp,
    output logic              irWrite,
    output logic              memRead,
    output logic              memWrite,
    output logic              pcWrite,
    output logic              regWrite,
    output logic              busFault
);
    import ctrlPkg::*;

    phaseT      phase;
    instrClassT instrClass;
    logic       busStalled;
    logic       timeout;

    ctrlSequencer sequencer (
        .clk(clk), .rst(rst), .waitRequest(waitRequest), .timeout(timeout),
        .instrClass(instrClass), .phase(phase), .busStalled(busStalled)
    );

    instrDecoder decoder (
        .clk(clk), .rst(rst), .phase(phase), .opcode(opcode), .funct(funct),
        .rtField(rtField), .instrClass(instrClass)
    );

    busWatchdog watchdog (
        .clk(clk), .rst(rst), .busStalled(busStalled), .timeout(timeout)
    );

    controlEncoder encoder (
        .phase(phase), .instrClass(instrClass), .waitRequest(waitRequest),
        .branchTaken(branchTaken), .memToReg(memToReg), .regDst(regDst),
        .pcSrc(pcSrc), .iorD(iorD), .aluSrcA(aluSrcA), .aluSrcB(aluSrcB),
        .extendMode(extendMode), .aluOp(aluOp), .irWrite(irWrite),
        .memRead(memRead), .memWrite(memWrite), .pcWrite(pcWrite),
        .regWrite(regWrite), .busFault(busFault)
    );

endmodule

/* hdl/ctrlPkg.sv */
package ctrlPkg;

    typedef logic [5:0] opcodeT;
    typedef logic [5:0] functT;
    typedef logic [4:0] rtFieldT;

    // primary opcodes.
    localparam opcodeT opSpecial = 6'b000000;
    localparam opcodeT opRegimm  = 6'b000001; // bgez and bltz, told apart by rt.
    localparam opcodeT opJ       = 6'b000010;
    localparam opcodeT opJal     = 6'b000011;
    localparam opcodeT opBeq     = 6'b000100;
    localparam opcodeT opBne     = 6'b000101;
    localparam opcodeT opAddiu   = 6'b001001;
    localparam opcodeT opSlti    = 6'b001010;
    localparam opcodeT opSltiu   = 6'b001011;
    localparam opcodeT opAndi    = 6'b001100;
    localparam opcodeT opOri     = 6'b001101;
    localparam opcodeT opXori    = 6'b001110;
    localparam opcodeT opLui     = 6'b001111;
    localparam opcodeT opLw      = 6'b100011;
    localparam opcodeT opSw      = 6'b101011;

    // function codes under opSpecial.
    localparam functT functJr   = 6'b001000;
    localparam functT functAddu = 6'b100001;
    localparam functT functSubu = 6'b100011;
    localparam functT functAnd  = 6'b100100;
    localparam functT functOr   = 6'b100101;
    localparam functT functXor  = 6'b100110;
    localparam functT functSlt  = 6'b101010;
    localparam functT functSltu = 6'b101011;

    localparam rtFieldT rtBltz = 5'b00000;
    localparam rtFieldT rtBgez = 5'b00001;

    typedef enum logic [4:0] {
        classAddu, classSubu, classAnd, classOr, classXor, classSlt, classSltu,
        classAddiu, classAndi, classOri, classXori, classSlti, classSltiu, classLui,
        classLw, classSw, classBeq, classBne, classBgez, classBltz,
        classJ, classJal, classJr, classNop
    } instrClassT;

    typedef enum logic [2:0] {
        phaseFetch, phaseDecode, phaseExecute, phaseAluWb, phaseMem, phaseLoadWb, phaseFault
    } phaseT;

    typedef enum logic [1:0] {wbAlu, wbMem, wbSltFlag, wbLinkPc} memToRegT;
    typedef enum logic [1:0] {dstRt, dstRd, dstRa} regDstT;
    typedef enum logic [1:0] {pcSeq, pcBranchTarget, pcJumpTarget, pcRegA} pcSrcT;
    typedef enum logic {addrPc, addrAluOut} iorDT;
    typedef enum logic [1:0] {srcAPc, srcARegA, srcAZero} aluSrcAT;
    typedef enum logic [1:0] {srcBRegB, srcBFour, srcBSignImm, srcBUpperImm} aluSrcBT;
    typedef enum logic {extZero, extSign} extendT;
    typedef enum logic [3:0] {aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluSltu} aluOpT;

    localparam int busTimeoutCycles = 16; // consecutive stalled cycles before a fault.
    localparam int stallCountWidth  = $clog2(busTimeoutCycles + 1);
    typedef logic [stallCountWidth-1:0] stallCountT;

    function automatic logic isRTypeAlu(instrClassT c);
        return c inside {classAddu, classSubu, classAnd, classOr, classXor, classSlt, classSltu};
    endfunction

    // ALU classes end with a register writeback of the ALU result.
    function automatic logic isAluClass(instrClassT c);
        return isRTypeAlu(c) || (c inside {classAddiu, classAndi, classOri, classXori,
                                           classSlti, classSltiu, classLui});
    endfunction

    function automatic logic isBranch(instrClassT c);
        return c inside {classBeq, classBne, classBgez, classBltz};
    endfunction

    function automatic logic isSltFamily(instrClassT c);
        return c inside {classSlt, classSltu, classSlti, classSltiu};
    endfunction

endpackage

/* hdl/ctrlSequencer.sv */
`timescale 1ns/1ps

module ctrlSequencer (
    input  logic                clk,
    input  logic                rst,
    input  logic                waitRequest,
    input  logic                timeout,
    input  ctrlPkg::instrClassT instrClass,
    output ctrlPkg::phaseT      phase,
    output logic                busStalled
);
    import ctrlPkg::*;

    phaseT nextPhase;
    logic  memPhase;

    assign memPhase   = (phase == phaseFetch) || (phase == phaseMem);
    assign busStalled = memPhase && waitRequest; // memory busy during an access.

    always_comb begin
        nextPhase = phase;
        case (phase)
            phaseFetch: begin
                if (!waitRequest) begin
                    nextPhase = phaseDecode;
                end
            end
            phaseDecode: begin
                nextPhase = phaseExecute;
            end
            phaseExecute: begin
                if (isAluClass(instrClass)) begin
                    nextPhase = phaseAluWb;
                end else if (instrClass == classLw || instrClass == classSw) begin
                    nextPhase = phaseMem;
                end else begin
                    nextPhase = phaseFetch; // branches, jumps and nops end here.
                end
            end
            phaseAluWb: begin
                nextPhase = phaseFetch;
            end
            phaseMem: begin
                if (!waitRequest) begin
                    if (instrClass == classLw) begin
                        nextPhase = phaseLoadWb;
                    end else begin
                        nextPhase = phaseFetch;
                    end
                end
            end
            phaseLoadWb: begin
                nextPhase = phaseFetch;
            end
            phaseFault: begin
                nextPhase = phaseFault; // sticky.
            end
            default: begin
                nextPhase = phaseFault;
            end
        endcase

        // a bus that never answers overrides every phase.
        if (timeout) begin
            nextPhase = phaseFault;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= phaseFetch;
        end else begin
            phase <= nextPhase;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        (phase == phaseFault) |=> (phase == phaseFault));

endmodule

/* hdl/instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder (
    input  logic                clk,
    input  logic                rst,
    input  ctrlPkg::phaseT      phase,
    input  ctrlPkg::opcodeT     opcode,
    input  ctrlPkg::functT      funct,
    input  ctrlPkg::rtFieldT    rtField,
    output ctrlPkg::instrClassT instrClass
);
    import ctrlPkg::*;

    instrClassT decodedClass;

    // fields are only meaningful while the fetched word sits in the decode cycle.
    always_comb begin
        decodedClass = classNop;
        if (opcode == opSpecial) begin
            case (funct)
                functAddu: decodedClass = classAddu;
                functSubu: decodedClass = classSubu;
                functAnd:  decodedClass = classAnd;
                functOr:   decodedClass = classOr;
                functXor:  decodedClass = classXor;
                functSlt:  decodedClass = classSlt;
                functSltu: decodedClass = classSltu;
                functJr:   decodedClass = classJr;
                default:   decodedClass = classNop;
            endcase
        end else if (opcode == opRegimm) begin
            if (rtField == rtBgez) begin
                decodedClass = classBgez;
            end else if (rtField == rtBltz) begin
                decodedClass = classBltz;
            end
            // the link variants fall through as nop.
        end else begin
            case (opcode)
                opAddiu: decodedClass = classAddiu;
                opAndi:  decodedClass = classAndi;
                opOri:   decodedClass = classOri;
                opXori:  decodedClass = classXori;
                opSlti:  decodedClass = classSlti;
                opSltiu: decodedClass = classSltiu;
                opLui:   decodedClass = classLui;
                opLw:    decodedClass = classLw;
                opSw:    decodedClass = classSw;
                opBeq:   decodedClass = classBeq;
                opBne:   decodedClass = classBne;
                opJ:     decodedClass = classJ;
                opJal:   decodedClass = classJal;
                default: decodedClass = classNop;
            endcase
        end
    end

    // held for every later phase of the instruction.
    always_ff @(posedge clk) begin
        if (rst) begin
            instrClass <= classNop;
        end else if (phase == phaseDecode) begin
            instrClass <= decodedClass;
        end
    end

endmodule

/* sources.f */
hdl/ctrlPkg.sv
hdl/instrDecoder.sv
hdl/ctrlSequencer.sv
hdl/busWatchdog.sv
hdl/controlEncoder.sv
hdl/controlUnit.sv
verif/controlUnitTb.sv

/* verif/controlUnitTb.sv */
`timescale 1ns/1ps

module controlUnitTb;
    import ctrlPkg::*;

    localparam int halfPeriod  = 4;
    localparam int numRandom   = 100;
    localparam int maxEntries  = 32;
    localparam int worstCycles = 11; // lw with three fetch and three memory waits.
    localparam int cycleLimit  = (maxEntries + numRandom) * worstCycles + 8 * busTimeoutCycles;

    typedef struct packed {
        memToRegT memToReg;
        regDstT   regDst;
        pcSrcT    pcSrc;
        iorDT     iorD;
        aluSrcAT  aluSrcA;
        aluSrcBT  aluSrcB;
        extendT   extendMode;
        aluOpT    aluOp;
        logic     irWrite;
        logic     memRead;
        logic     memWrite;
        logic     pcWrite;
        logic     regWrite;
        logic     busFault;
    } ctrlT;

    logic     clk;
    logic     rst;
    opcodeT   opcode;
    functT    funct;
    rtFieldT  rtField;
    logic     waitRequest;
    logic     branchTaken;
    memToRegT memToReg;
    regDstT   regDst;
    pcSrcT    pcSrc;
    iorDT     iorD;
    aluSrcAT  aluSrcA;
    aluSrcBT  aluSrcB;
    extendT   extendMode;
    aluOpT    aluOp;
    logic     irWrite;
    logic     memRead;
    logic     memWrite;
    logic     pcWrite;
    logic     regWrite;
    logic     busFault;

    // one table entry per encoding under test.
    opcodeT     tblOp[$];
    functT      tblFn[$];
    rtFieldT    tblRt[$];
    instrClassT tblCls[$];

    phaseT       modelPhase;
    instrClassT  modelClass;
    instrClassT  pendingClass;
    int          modelCount;
    logic        stalled;
    logic        expired;
    ctrlT        expected;
    ctrlT        actual;
    int          checkCount = 0;
    int          errorCount = 0;
    int          cycleCount;
    logic [31:0] rngState;

    controlUnit UUT (
        .clk(clk), .rst(rst), .opcode(opcode), .funct(funct), .rtField(rtField),
        .waitRequest(waitRequest), .branchTaken(branchTaken), .memToReg(memToReg),
        .regDst(regDst), .pcSrc(pcSrc), .iorD(iorD), .aluSrcA(aluSrcA),
        .aluSrcB(aluSrcB), .extendMode(extendMode), .aluOp(aluOp), .irWrite(irWrite),
        .memRead(memRead), .memWrite(memWrite), .pcWrite(pcWrite),
        .regWrite(regWrite), .busFault(busFault)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic drawRandom(input int range, output int value);
        rngState = xorshift32(rngState);
        value = int'(rngState % range);
    endtask

    function automatic logic regRegOp(input instrClassT c);
        case (c)
            classAddu, classSubu, classAnd, classOr, classXor, classSlt, classSltu: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic immOp(input instrClassT c);
        case (c)
            classAddiu, classAndi, classOri, classXori, classSlti, classSltiu, classLui: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic aluOpT opForClass(input instrClassT c);
        case (c)
            classSubu, classBeq, classBne, classBgez, classBltz: return aluSub;
            classAnd, classAndi: return aluAnd;
            classOr, classOri: return aluOr;
            classXor, classXori: return aluXor;
            classSlt, classSlti: return aluSlt;
            classSltu, classSltiu: return aluSltu;
            default: return aluAdd;
        endcase
    endfunction

    function automatic aluSrcBT srcBForClass(input instrClassT c);
        if (regRegOp(c) || c inside {classBeq, classBne, classBgez, classBltz}) begin
            return srcBRegB;
        end
        case (c)
            classLui: return srcBUpperImm;
            classAddiu, classAndi, classOri, classXori, classSlti, classSltiu,
            classLw, classSw: return srcBSignImm;
            default: return srcBFour; // jumps and nops keep the default.
        endcase
    endfunction

    // expected control word for one cycle of the phase model.
    function automatic ctrlT expectedCtrl(input phaseT ph, input instrClassT cls,
                                          input logic wr, input logic bt);
        ctrlT e;
        e = '0;
        e.memToReg   = wbAlu;
        e.regDst     = dstRt;
        e.pcSrc      = pcSeq;
        e.iorD       = addrPc;
        e.aluSrcA    = srcAPc;
        e.aluSrcB    = srcBFour;
        e.extendMode = extSign;
        e.aluOp      = aluAdd;
        case (ph)
            phaseFetch: begin
                e.memRead = 1'b1;
                e.irWrite = !wr;
                e.pcWrite = !wr;
            end
            phaseExecute: begin
                e.aluSrcA = (cls == classLui) ? srcAZero : srcARegA;
                e.aluSrcB = srcBForClass(cls);
                e.aluOp   = opForClass(cls);
                if (cls inside {classAndi, classOri, classXori}) begin
                    e.extendMode = extZero;
                end
                case (cls)
                    classBeq, classBne, classBgez, classBltz: begin
                        e.pcSrc   = pcBranchTarget;
                        e.pcWrite = bt;
                    end
                    classJ: begin
                        e.pcSrc   = pcJumpTarget;
                        e.pcWrite = 1'b1;
                    end
                    classJal: begin
                        e.pcSrc    = pcJumpTarget;
                        e.pcWrite  = 1'b1;
                        e.regWrite = 1'b1;
                        e.regDst   = dstRa;
                        e.memToReg = wbLinkPc;
                    end
                    classJr: begin
                        e.pcSrc   = pcRegA;
                        e.pcWrite = 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
            phaseAluWb: begin
                e.regWrite = 1'b1;
                e.regDst   = regRegOp(cls) ? dstRd : dstRt;
                if (cls inside {classSlt, classSltu, classSlti, classSltiu}) begin
                    e.memToReg = wbSltFlag;
                end
            end
            phaseMem: begin
                e.iorD     = addrAluOut;
                e.memRead  = (cls == classLw);
                e.memWrite = (cls == classSw);
            end
            phaseLoadWb: begin
                e.regWrite = 1'b1;
                e.memToReg = wbMem;
            end
            phaseFault: e.busFault = 1'b1;
            default: begin
            end
        endcase
        return e;
    endfunction

    function automatic phaseT nextModelPhase(input phaseT ph, input instrClassT cls,
                                             input logic wr, input logic limitHit);
        if (limitHit || ph == phaseFault) begin
            return phaseFault;
        end
        case (ph)
            phaseFetch: return wr ? phaseFetch : phaseDecode;
            phaseDecode: return phaseExecute;
            phaseExecute: begin
                if (regRegOp(cls) || immOp(cls)) begin
                    return phaseAluWb;
                end
                return (cls == classLw || cls == classSw) ? phaseMem : phaseFetch;
            end
            phaseMem: begin
                if (wr) begin
                    return phaseMem;
                end
                return (cls == classLw) ? phaseLoadWb : phaseFetch;
            end
            default: return phaseFetch;
        endcase
    endfunction

    // compares the DUT with the model, then steps the model.
    always @(posedge clk) begin
        if (rst) begin
            modelPhase = phaseFetch;
            modelClass = classNop;
            modelCount = 0;
        end else begin
            expected = expectedCtrl(modelPhase, modelClass, waitRequest, branchTaken);
            actual   = {memToReg, regDst, pcSrc, iorD, aluSrcA, aluSrcB, extendMode, aluOp,
                        irWrite, memRead, memWrite, pcWrite, regWrite, busFault};
            checkCount++;
            assert (actual === expected) else begin
                errorCount++;
                $display("ERROR at %0t: phase %s class %s, control %h expected %h", $time,
                         modelPhase.name(), modelClass.name(), actual, expected);
            end
            stalled = (modelPhase == phaseFetch || modelPhase == phaseMem) && waitRequest;
            expired = (modelCount == busTimeoutCycles);
            if (modelPhase == phaseDecode) begin
                modelClass = pendingClass;
            end
            modelPhase = nextModelPhase(modelPhase, modelClass, waitRequest, expired);
            modelCount = stalled ? (expired ? modelCount : modelCount + 1) : 0;
        end
    end

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        $display("timeout: the run did not finish within %0d cycles", cycleLimit);
        $display("sim failed");
        $finish;
    end

    task automatic addEntry(input opcodeT op, input functT fn, input rtFieldT rt,
                            input instrClassT cls);
        tblOp.push_back(op);
        tblFn.push_back(fn);
        tblRt.push_back(rt);
        tblCls.push_back(cls);
    endtask

    task automatic fillTable();
        addEntry(opSpecial, functAddu, 5'h03, classAddu);
        addEntry(opSpecial, functSubu, 5'h03, classSubu);
        addEntry(opSpecial, functAnd, 5'h03, classAnd);
        addEntry(opSpecial, functOr, 5'h03, classOr);
        addEntry(opSpecial, functXor, 5'h03, classXor);
        addEntry(opSpecial, functSlt, 5'h03, classSlt);
        addEntry(opSpecial, functSltu, 5'h03, classSltu);
        addEntry(opSpecial, functJr, 5'h00, classJr);
        addEntry(opAddiu, functSubu, 5'h04, classAddiu); // funct bits are immediate here.
        addEntry(opAndi, 6'h3f, 5'h04, classAndi);
        addEntry(opOri, 6'h10, 5'h04, classOri);
        addEntry(opXori, 6'h00, 5'h04, classXori);
        addEntry(opSlti, functSlt, 5'h04, classSlti);
        addEntry(opSltiu, 6'h01, 5'h04, classSltiu);
        addEntry(opLui, 6'h22, 5'h04, classLui);
        addEntry(opLw, 6'h04, 5'h05, classLw);
        addEntry(opSw, 6'h08, 5'h05, classSw);
        addEntry(opBeq, 6'h02, 5'h06, classBeq);
        addEntry(opBne, 6'h02, 5'h06, classBne);
        addEntry(opRegimm, 6'h02, rtBgez, classBgez);
        addEntry(opRegimm, 6'h02, rtBltz, classBltz);
        addEntry(opJ, 6'h15, 5'h0a, classJ);
        addEntry(opJal, 6'h15, 5'h0a, classJal);
        addEntry(6'b011100, 6'h02, 5'h01, classNop); // unknown opcodes decode as nop.
        addEntry(opSpecial, 6'b000000, 5'h01, classNop);
        addEntry(opRegimm, 6'h00, 5'b10001, classNop);
        addEntry(6'b100000, 6'h00, 5'h01, classNop);
    endtask

    // drives one instruction from fetch back to the next fetch.
    task automatic runInstr(input int idx, input int fetchWaits, input int memWaits);
        int   fw;
        int   mw;
        int   r;
        logic left;
        fw = fetchWaits;
        mw = memWaits;
        left = 1'b0;
        pendingClass = tblCls[idx];
        while (!(left && modelPhase == phaseFetch) && modelPhase != phaseFault) begin
            drawRandom(2, r);
            branchTaken = r[0];
            drawRandom(2, r);
            waitRequest = r[0]; // ignored outside fetch and memory.
            case (modelPhase)
                phaseFetch: begin
                    waitRequest = (fw > 0);
                    fw = (fw > 0) ? fw - 1 : 0;
                end
                phaseMem: begin
                    waitRequest = (mw > 0);
                    mw = (mw > 0) ? mw - 1 : 0;
                end
                phaseDecode: begin
                    opcode  = tblOp[idx];
                    funct   = tblFn[idx];
                    rtField = tblRt[idx];
                end
                default: begin
                end
            endcase
            @(negedge clk);
            if (modelPhase != phaseFetch) begin
                left = 1'b1;
            end
        end
    endtask

    task automatic faultTest();
        int r;
        waitRequest = 1'b1;
        repeat (busTimeoutCycles + 2) @(negedge clk);
        checkCount++;
        assert (busFault === 1'b1) else begin
            errorCount++;
            $display("ERROR at %0t: bus fault was not raised by a stalled fetch", $time);
        end
        repeat (8) begin
            drawRandom(2, r);
            waitRequest = r[0];
            drawRandom(2, r);
            branchTaken = r[0];
            @(negedge clk);
        end
        rst = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        waitRequest = 1'b0;
        runInstr(0, 1, 0); // one instruction after the reset clears the fault.
    endtask

    initial begin
        int pick;
        int fw;
        int mw;
        rst         = 1'b1;
        opcode      = '0;
        funct       = '0;
        rtField     = '0;
        waitRequest = 1'b0;
        branchTaken = 1'b0;
        rngState    = 32'd17225;
        fillTable();
        repeat (2) @(negedge clk);
        rst = 1'b0;
        foreach (tblCls[i]) begin
            drawRandom(4, fw);
            drawRandom(4, mw);
            runInstr(i, fw, mw);
        end
        for (int n = 0; n < numRandom; n++) begin
            drawRandom(tblCls.size(), pick);
            drawRandom(4, fw);
            drawRandom(4, mw);
            runInstr(pick, fw, mw);
        end
        faultTest();
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
